// File: hw/ex_pkg.sv
package ex_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;  // first fetch address

    // anything outside this list is reported as illegal
    typedef enum logic [4:0] {
        ALU_ADD   = 5'h00,
        ALU_SUB   = 5'h01,
        ALU_AND   = 5'h02,
        ALU_OR    = 5'h03,
        ALU_XOR   = 5'h04,
        ALU_SLL   = 5'h05,
        ALU_SRL   = 5'h06,
        ALU_SRA   = 5'h07,
        ALU_SLT   = 5'h08,
        ALU_SLTU  = 5'h09,
        ALU_PASSB = 5'h0a,  // lui style pass-through
        ALU_ADDW  = 5'h10,
        ALU_SUBW  = 5'h11,
        ALU_SLLW  = 5'h12,
        ALU_SRLW  = 5'h13,
        ALU_SRAW  = 5'h14
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       alu_src1;    // also the store base
        logic [XLEN-1:0]       alu_src2;
        logic [31:0]           s_imm;       // store offset
        logic [XLEN-1:0]       store_data;
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] reg_waddr;
        logic                  s_flag;      // store
        logic [1:0]            wmask_len;   // 0:1B 1:2B 2:4B 3:8B
        logic                  link;        // jal/jalr write pc+4
        logic                  word_op;     // 32-bit result, sign extended
        logic                  ebreak;
    } uop_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       wdata;
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] reg_waddr;
        logic                  st_en;
        logic [XLEN-1:0]       st_addr;
        logic [XLEN-1:0]       st_data;     // already lane aligned
        logic [7:0]            st_strb;
        logic                  halt;
        logic                  illegal;
        logic                  misaligned;
    } ex_res_t;

endpackage

// File: hw/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type      payload_t = logic,
    parameter payload_t RESET_VAL = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // no stall or flush, the stage advances every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
            data_o  <= RESET_VAL;
        end else begin
            valid_o <= valid_i;
            data_o  <= data_i;       // loads even on a bubble
        end
    end

    // an X on valid would leak into every downstream enable
    a_valid_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(valid_o)
    ) else $error("pipe_reg: valid_o is unknown");

endmodule

// File: hw/alu_unit.sv
`timescale 1ns/1ns

module alu_unit #(
    parameter int XLEN_P = 64
) (
    input  ex_pkg::alu_op_e    op_i,
    input  logic [XLEN_P-1:0]  src1_i,
    input  logic [XLEN_P-1:0]  src2_i,
    output logic [XLEN_P-1:0]  result_o,
    output logic               illegal_o
);

    localparam int SHW = $clog2(XLEN_P);

    logic [SHW-1:0] shamt;
    logic [4:0]     shamt_w;
    logic [31:0]    w_res;           // word form result before extension
    logic           is_word;

    assign shamt   = src2_i[SHW-1:0];
    assign shamt_w = src2_i[4:0];    // word shifts use 5 bits only

    always_comb begin
        result_o  = '0;
        w_res     = '0;
        is_word   = 1'b0;
        illegal_o = 1'b0;
        case (op_i)
            ex_pkg::ALU_ADD:   result_o = src1_i + src2_i;
            ex_pkg::ALU_SUB:   result_o = src1_i - src2_i;
            ex_pkg::ALU_AND:   result_o = src1_i & src2_i;
            ex_pkg::ALU_OR:    result_o = src1_i | src2_i;
            ex_pkg::ALU_XOR:   result_o = src1_i ^ src2_i;
            ex_pkg::ALU_SLL:   result_o = src1_i << shamt;
            ex_pkg::ALU_SRL:   result_o = src1_i >> shamt;
            ex_pkg::ALU_SRA:   result_o = XLEN_P'($signed(src1_i) >>> shamt);
            ex_pkg::ALU_SLT:   result_o = XLEN_P'($signed(src1_i) < $signed(src2_i));
            ex_pkg::ALU_SLTU:  result_o = XLEN_P'(src1_i < src2_i);
            ex_pkg::ALU_PASSB: result_o = src2_i;
            ex_pkg::ALU_ADDW: begin
                w_res   = src1_i[31:0] + src2_i[31:0];
                is_word = 1'b1;
            end
            ex_pkg::ALU_SUBW: begin
                w_res   = src1_i[31:0] - src2_i[31:0];
                is_word = 1'b1;
            end
            ex_pkg::ALU_SLLW: begin
                w_res   = src1_i[31:0] << shamt_w;
                is_word = 1'b1;
            end
            ex_pkg::ALU_SRLW: begin
                w_res   = src1_i[31:0] >> shamt_w;
                is_word = 1'b1;
            end
            ex_pkg::ALU_SRAW: begin
                w_res   = 32'($signed(src1_i[31:0]) >>> shamt_w);
                is_word = 1'b1;
            end
            default: begin
                illegal_o = 1'b1;    // result stays zero
            end
        endcase
        if (is_word) begin
            result_o = {{(XLEN_P-32){w_res[31]}}, w_res};
        end
    end

endmodule

// File: hw/store_unit.sv
`timescale 1ns/1ns

module store_unit (
    input  ex_pkg::uop_t uop_i,
    output logic [63:0]  st_addr_o,
    output logic [63:0]  st_data_o,
    output logic [7:0]   st_strb_o,
    output logic         misaligned_o
);

    logic [63:0] offset;
    logic [2:0]  lane;           // byte position inside the doubleword
    logic [7:0]  base_strb;
    logic [2:0]  size_mask;      // low address bits that must be zero

    assign offset    = {{32{uop_i.s_imm[31]}}, uop_i.s_imm};
    assign st_addr_o = uop_i.alu_src1 + offset;
    assign lane      = st_addr_o[2:0];

    always_comb begin
        case (uop_i.wmask_len)
            2'd0: begin
                base_strb = 8'h01;   // sb
                size_mask = 3'b000;
            end
            2'd1: begin
                base_strb = 8'h03;   // sh
                size_mask = 3'b001;
            end
            2'd2: begin
                base_strb = 8'h0f;   // sw
                size_mask = 3'b011;
            end
            default: begin
                base_strb = 8'hff;   // sd
                size_mask = 3'b111;
            end
        endcase
    end

    assign misaligned_o = uop_i.s_flag && ((lane & size_mask) != 3'b000);

    // aligned accesses never cross the doubleword, so no bits fall off
    assign st_strb_o = (uop_i.s_flag && !misaligned_o) ? (base_strb << lane) : 8'h00;
    assign st_data_o = uop_i.store_data << {lane, 3'b000};

    // non-store micro-ops must not touch memory lanes
    always_comb begin
        assert (uop_i.s_flag || st_strb_o == 8'h00)
            else $error("store_unit: strobe set without s_flag");
    end

endmodule

// File: hw/ex_result_sel.sv
`timescale 1ns/1ns

module ex_result_sel (
    input  ex_pkg::uop_t                uop_i,
    input  logic                        valid_i,
    input  logic [ex_pkg::XLEN-1:0]     alu_result_i,
    input  logic                        alu_illegal_i,
    input  logic [63:0]                 st_addr_i,
    input  logic [63:0]                 st_data_i,
    input  logic [7:0]                  st_strb_i,
    input  logic                        st_misaligned_i,
    output ex_pkg::ex_res_t             res_o
);

    logic [ex_pkg::XLEN-1:0] link_val;
    logic [ex_pkg::XLEN-1:0] alu_val;
    logic                    illegal;
    logic                    misaligned;

    assign link_val   = uop_i.pc + 64'd4;
    assign illegal    = valid_i && alu_illegal_i;
    assign misaligned = valid_i && uop_i.s_flag && st_misaligned_i;

    // word micro-ops keep only the low half, sign extended
    assign alu_val = uop_i.word_op ?
                     {{(ex_pkg::XLEN-32){alu_result_i[31]}}, alu_result_i[31:0]} :
                     alu_result_i;

    always_comb begin
        res_o            = '0;
        res_o.pc         = uop_i.pc;
        res_o.wdata      = uop_i.link ? link_val : alu_val;
        res_o.reg_waddr  = uop_i.reg_waddr;
        res_o.reg_wen    = valid_i && uop_i.reg_wen && !uop_i.s_flag && !illegal
                           && (uop_i.reg_waddr != '0);     // x0 is hardwired
        res_o.st_en      = valid_i && uop_i.s_flag && !misaligned;
        res_o.st_addr    = st_addr_i;
        res_o.st_data    = st_data_i;
        res_o.st_strb    = res_o.st_en ? st_strb_i : 8'h00;
        res_o.halt       = valid_i && uop_i.ebreak;
        res_o.illegal    = illegal;
        res_o.misaligned = misaligned;
    end

    // a micro-op is either a register write or a store, never both
    always_comb begin
        assert (!(res_o.st_en && res_o.reg_wen))
            else $error("ex_result_sel: store and register write together");
    end

endmodule

// File: hw/ex_stage_top.sv
`timescale 1ns/1ns

module ex_stage_top #(
    parameter int XLEN_P = 64
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  ex_pkg::uop_t                    uop_i,
    input  logic                            uop_valid_i,
    output logic                            wb_valid_o,
    output logic                            wb_we_o,
    output logic [ex_pkg::REG_ADDR_W-1:0]   wb_addr_o,
    output logic [XLEN_P-1:0]               wb_data_o,
    output logic                            st_en_o,
    output logic [63:0]                     st_addr_o,
    output logic [63:0]                     st_data_o,
    output logic [7:0]                      st_strb_o,
    output logic                            halt_o,
    output logic                            illegal_o,
    output logic                            misaligned_o
);

    localparam ex_pkg::uop_t UOP_RST = '{
        pc:      ex_pkg::RESET_PC,
        alu_op:  ex_pkg::ALU_ADD,
        default: '0
    };
    localparam ex_pkg::ex_res_t RES_RST = '{pc: ex_pkg::RESET_PC, default: '0};

    // uop_t and ex_res_t are sized by the package width
    if (XLEN_P != ex_pkg::XLEN) begin : g_width_check
        $error("ex_stage_top: XLEN_P must equal ex_pkg::XLEN");
    end

    ex_pkg::uop_t    ex_uop;
    logic            ex_valid;
    logic [XLEN_P-1:0] alu_result;
    logic            alu_illegal;
    logic [63:0]     st_addr;
    logic [63:0]     st_data;
    logic [7:0]      st_strb;
    logic            st_misaligned;
    ex_pkg::ex_res_t ex_res;
    ex_pkg::ex_res_t wb_res;
    logic            wb_valid;

    pipe_reg #(.payload_t(ex_pkg::uop_t), .RESET_VAL(UOP_RST)) i_id_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (uop_valid_i),
        .data_i  (uop_i),
        .valid_o (ex_valid),
        .data_o  (ex_uop)
    );

    alu_unit #(.XLEN_P(XLEN_P)) i_alu (
        .op_i      (ex_uop.alu_op),
        .src1_i    (ex_uop.alu_src1),
        .src2_i    (ex_uop.alu_src2),
        .result_o  (alu_result),
        .illegal_o (alu_illegal)
    );

    store_unit i_store (
        .uop_i        (ex_uop),
        .st_addr_o    (st_addr),
        .st_data_o    (st_data),
        .st_strb_o    (st_strb),
        .misaligned_o (st_misaligned)
    );

    ex_result_sel i_sel (
        .uop_i           (ex_uop),
        .valid_i         (ex_valid),
        .alu_result_i    (alu_result),
        .alu_illegal_i   (alu_illegal),
        .st_addr_i       (st_addr),
        .st_data_i       (st_data),
        .st_strb_i       (st_strb),
        .st_misaligned_i (st_misaligned),
        .res_o           (ex_res)
    );

    pipe_reg #(.payload_t(ex_pkg::ex_res_t), .RESET_VAL(RES_RST)) i_ex_wb (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (ex_valid),
        .data_i  (ex_res),
        .valid_o (wb_valid),
        .data_o  (wb_res)
    );

    assign wb_valid_o   = wb_valid;
    assign wb_we_o      = wb_valid && wb_res.reg_wen;
    assign wb_addr_o    = wb_valid ? wb_res.reg_waddr : '0;
    assign wb_data_o    = wb_valid ? wb_res.wdata : '0;
    assign st_en_o      = wb_valid && wb_res.st_en;
    assign st_addr_o    = wb_valid ? wb_res.st_addr : '0;
    assign st_data_o    = wb_valid ? wb_res.st_data : '0;
    assign st_strb_o    = wb_valid ? wb_res.st_strb : '0;
    assign halt_o       = wb_valid && wb_res.halt;
    assign illegal_o    = wb_valid && wb_res.illegal;
    assign misaligned_o = wb_valid && wb_res.misaligned;

endmodule

// File: sim/tb_ex_stage.sv
`timescale 1ns/1ns

module tb_ex_stage;

    localparam int DRAIN_LIMIT = 16;  // idle cycles allowed to empty the queue
    localparam int VALID_LIMIT = 8;

    typedef struct packed {
        logic        valid;
        logic        we;
        logic [4:0]  addr;
        logic [63:0] data;
        logic        st_en;
        logic [63:0] st_addr;
        logic [63:0] st_data;
        logic [7:0]  st_strb;
        logic        halt;
        logic        illegal;
        logic        misaligned;
    } exp_t;

    typedef struct {
        int unsigned due;  // cycle whose edge puts the result on the outputs
        exp_t        rec;
    } pend_t;

    logic         clk;
    logic         rst_n;
    ex_pkg::uop_t uop_i;
    logic         uop_valid_i;
    logic         wb_valid_o;
    logic         wb_we_o;
    logic [4:0]   wb_addr_o;
    logic [63:0]  wb_data_o;
    logic         st_en_o;
    logic [63:0]  st_addr_o;
    logic [63:0]  st_data_o;
    logic [7:0]   st_strb_o;
    logic         halt_o;
    logic         illegal_o;
    logic         misaligned_o;

    logic [31:0]  rng;
    pend_t        pend_q[$];
    exp_t         exp_cur;  // what the outputs should show since the last edge
    int unsigned  cyc;
    int           err_cnt;
    int           fail_cnt;
    int           test_cnt;
    int           fail_mark;

    ex_pkg::alu_op_e legal_ops [16] = '{
        ex_pkg::ALU_ADD, ex_pkg::ALU_SUB, ex_pkg::ALU_AND, ex_pkg::ALU_OR,
        ex_pkg::ALU_XOR, ex_pkg::ALU_SLL, ex_pkg::ALU_SRL, ex_pkg::ALU_SRA,
        ex_pkg::ALU_SLT, ex_pkg::ALU_SLTU, ex_pkg::ALU_PASSB, ex_pkg::ALU_ADDW,
        ex_pkg::ALU_SUBW, ex_pkg::ALU_SLLW, ex_pkg::ALU_SRLW, ex_pkg::ALU_SRAW
    };

    ex_stage_top #(.XLEN_P(64)) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .uop_i        (uop_i),
        .uop_valid_i  (uop_valid_i),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .st_en_o      (st_en_o),
        .st_addr_o    (st_addr_o),
        .st_data_o    (st_data_o),
        .st_strb_o    (st_strb_o),
        .halt_o       (halt_o),
        .illegal_o    (illegal_o),
        .misaligned_o (misaligned_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [63:0] rand64();
        return {rand32(), rand32()};
    endfunction

    function automatic logic duty();
        return (rand32() & 32'd3) != 32'd0;  // about 3 in 4
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // expected outputs worked out from the opcode table and the store rules
    function automatic exp_t predict(input ex_pkg::uop_t u);
        exp_t        e;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [63:0] addr;
        logic [3:0]  size;
        logic        bad_op;
        a      = u.alu_src1;
        b      = u.alu_src2;
        r      = '0;
        bad_op = 1'b0;
        case (u.alu_op)
            ex_pkg::ALU_ADD:   r = a + b;
            ex_pkg::ALU_SUB:   r = a + ~b + 64'd1;  // two's complement form
            ex_pkg::ALU_AND:   r = a & b;
            ex_pkg::ALU_OR:    r = a | b;
            ex_pkg::ALU_XOR:   r = a ^ b;
            ex_pkg::ALU_SLL:   r = a << b[5:0];
            ex_pkg::ALU_SRL:   r = a >> b[5:0];
            ex_pkg::ALU_SRA:   r = $signed(a) >>> b[5:0];
            ex_pkg::ALU_SLT:   r = {63'd0, $signed(a) < $signed(b)};
            ex_pkg::ALU_SLTU:  r = {63'd0, a < b};
            ex_pkg::ALU_PASSB: r = b;
            ex_pkg::ALU_ADDW:  r = sext32(a[31:0] + b[31:0]);
            ex_pkg::ALU_SUBW:  r = sext32(a[31:0] - b[31:0]);
            ex_pkg::ALU_SLLW:  r = sext32(a[31:0] << b[4:0]);
            ex_pkg::ALU_SRLW:  r = sext32(32'({32'd0, a[31:0]} >> b[4:0]));
            ex_pkg::ALU_SRAW:  r = sext32(32'($signed(sext32(a[31:0])) >>> b[4:0]));
            default:           bad_op = 1'b1;
        endcase
        if (u.word_op) begin
            r = sext32(r[31:0]);
        end
        addr         = u.alu_src1 + sext32(u.s_imm);
        size         = 4'd1 << u.wmask_len;  // bytes
        e.valid      = 1'b1;
        e.illegal    = bad_op;
        e.misaligned = u.s_flag && ((addr % {60'd0, size}) != 64'd0);
        e.st_en      = u.s_flag && !e.misaligned;
        e.st_addr    = addr;
        e.st_data    = u.store_data << (8 * addr[2:0]);
        e.st_strb    = e.st_en ? 8'(((16'd1 << size) - 16'd1) << addr[2:0]) : 8'h00;
        e.data       = u.link ? u.pc + 64'd4 : r;
        e.addr       = u.reg_waddr;
        e.we         = u.reg_wen && !u.s_flag && !bad_op && (u.reg_waddr != 5'd0);
        e.halt       = u.ebreak;
        return e;
    endfunction

    function automatic ex_pkg::uop_t rand_uop();
        ex_pkg::uop_t u;
        logic [31:0]  r;
        r            = rand32();
        u            = '0;
        u.pc         = ex_pkg::RESET_PC + {32'd0, rand32() & 32'h000f_fffc};
        u.alu_op     = legal_ops[r[3:0]];
        u.alu_src1   = rand64();
        u.alu_src2   = rand64();
        u.s_imm      = rand32();
        u.store_data = rand64();
        u.reg_wen    = r[4];
        u.reg_waddr  = r[9:5];
        u.wmask_len  = r[11:10];
        return u;
    endfunction

    function void log_mismatch(input string sig, input logic [63:0] got,
                               input logic [63:0] want);
        err_cnt = err_cnt + 1;
        $display("[ERROR] %0t: %s is %h, expected %h", $time, sig, got, want);
    endfunction

    // one cycle of stimulus and the matching step of the expected queue
    task automatic drive(input logic v, input ex_pkg::uop_t u);
        pend_t p;
        @(posedge clk);
        cyc = cyc + 1;
        if (pend_q.size() != 0 && pend_q[0].due == cyc) begin
            exp_cur <= pend_q[0].rec;
            void'(pend_q.pop_front());
        end else begin
            exp_cur <= '0;  // bubble keeps everything gated low
        end
        uop_i       <= u;
        uop_valid_i <= v;
        if (v) begin
            p.due = cyc + 2;
            p.rec = predict(u);
            pend_q.push_back(p);
        end
    endtask

    task automatic idle();
        drive(1'b0, rand_uop());  // payload still toggles
    endtask

    task automatic wait_wb_valid(input string what);
        int n;
        n = 0;
        while (!wb_valid_o && n < VALID_LIMIT) begin
            idle();
            n = n + 1;
        end
        if (!wb_valid_o) begin
            $display("timeout: no writeback for %s within %0d cycles", what, VALID_LIMIT);
            fail_cnt = fail_cnt + 1;
        end
    endtask

    task automatic drain_pipe();
        int n;
        n = 0;
        while (pend_q.size() != 0 && n < DRAIN_LIMIT) begin
            idle();
            n = n + 1;
        end
        if (pend_q.size() != 0) begin
            $display("timeout: %0d results still pending after %0d idle cycles",
                     pend_q.size(), DRAIN_LIMIT);
            fail_cnt = fail_cnt + 1;
            pend_q.delete();
        end
        idle();  // last popped record is checked here
        @(negedge clk);  // mid cycle, after the assertion actions of that edge
    endtask

    task automatic end_test(input string name);
        drain_pipe();
        test_cnt = test_cnt + 1;
        $display("test %0d %s: %0d failures", test_cnt, name, err_cnt + fail_cnt - fail_mark);
        fail_mark = err_cnt + fail_cnt;
    endtask

    a_wb_valid : assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_o == exp_cur.valid)
        else log_mismatch("wb_valid_o", 64'($sampled(wb_valid_o)), 64'($sampled(exp_cur.valid)));
    a_wb_we : assert property (@(posedge clk) disable iff (!rst_n) wb_we_o == exp_cur.we)
        else log_mismatch("wb_we_o", 64'($sampled(wb_we_o)), 64'($sampled(exp_cur.we)));
    a_wb_addr : assert property (@(posedge clk) disable iff (!rst_n) wb_addr_o == exp_cur.addr)
        else log_mismatch("wb_addr_o", 64'($sampled(wb_addr_o)), 64'($sampled(exp_cur.addr)));
    a_wb_data : assert property (@(posedge clk) disable iff (!rst_n) wb_data_o == exp_cur.data)
        else log_mismatch("wb_data_o", $sampled(wb_data_o), $sampled(exp_cur.data));
    a_st_en : assert property (@(posedge clk) disable iff (!rst_n) st_en_o == exp_cur.st_en)
        else log_mismatch("st_en_o", 64'($sampled(st_en_o)), 64'($sampled(exp_cur.st_en)));
    a_st_addr : assert property (@(posedge clk) disable iff (!rst_n)
        st_addr_o == exp_cur.st_addr)
        else log_mismatch("st_addr_o", $sampled(st_addr_o), $sampled(exp_cur.st_addr));
    a_st_data : assert property (@(posedge clk) disable iff (!rst_n)
        st_data_o == exp_cur.st_data)
        else log_mismatch("st_data_o", $sampled(st_data_o), $sampled(exp_cur.st_data));
    a_st_strb : assert property (@(posedge clk) disable iff (!rst_n)
        st_strb_o == exp_cur.st_strb)
        else log_mismatch("st_strb_o", 64'($sampled(st_strb_o)), 64'($sampled(exp_cur.st_strb)));
    // halt, illegal and misaligned as one 3-bit group
    a_flags : assert property (@(posedge clk) disable iff (!rst_n)
        {halt_o, illegal_o, misaligned_o} == {exp_cur.halt, exp_cur.illegal, exp_cur.misaligned})
        else log_mismatch("halt/illegal/misaligned",
                          64'($sampled({halt_o, illegal_o, misaligned_o})),
                          64'($sampled({exp_cur.halt, exp_cur.illegal, exp_cur.misaligned})));

    initial begin
        ex_pkg::uop_t u;
        logic [31:0]  r;
        logic [4:0]   bad;
        int           i;
        rng         = 32'ha183_94e1;
        rst_n       = 1'b0;
        uop_i       = '0;
        uop_valid_i = 1'b0;
        exp_cur     = '0;
        cyc         = 0;
        err_cnt     = 0;
        fail_cnt    = 0;
        test_cnt    = 0;
        fail_mark   = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        repeat (4) idle();  // outputs must stay low
        drive(1'b1, rand_uop());
        wait_wb_valid("first micro-op");
        for (i = 0; i < 8; i++) begin
            drive(1'b1, rand_uop());  // back to back
        end
        end_test("reset and latency");

        for (i = 0; i < 200; i++) begin
            u         = rand_uop();
            u.word_op = u.alu_op[4];  // word forms live at 5'h10 and up
            drive(duty(), u);
        end
        end_test("alu operations");

        for (i = 0; i < 80; i++) begin
            r         = rand32();
            u         = rand_uop();
            u.link    = r[0];
            u.reg_wen = 1'b1;
            if (r[2:1] == 2'd0) begin
                u.reg_waddr = 5'd0;
            end
            drive(duty(), u);
        end
        end_test("link and x0");

        for (i = 0; i < 160; i++) begin
            r           = rand32();
            u           = rand_uop();
            u.s_flag    = 1'b1;
            u.reg_wen   = 1'b1;
            u.wmask_len = r[1:0];
            if (r[2]) begin  // force a size aligned address
                u.alu_src1 = (rand64() & ~((64'd1 << r[1:0]) - 64'd1)) - sext32(u.s_imm);
            end
            drive(duty(), u);
        end
        end_test("stores");

        for (i = 0; i < 80; i++) begin
            r           = rand32();
            u           = rand_uop();
            u.reg_wen   = 1'b1;
            u.reg_waddr = 5'd1 + {1'b0, r[8:5]};
            if (r[0]) begin
                bad      = r[4] ? 5'h15 + {2'b00, r[3:1]} : 5'h0b + {3'b000, r[2:1]};
                u.alu_op = ex_pkg::alu_op_e'(bad);
            end else begin
                u.ebreak = 1'b1;
            end
            drive(duty(), u);
        end
        end_test("illegal and ebreak");

        for (i = 0; i < 300; i++) begin
            r         = rand32();
            u         = rand_uop();
            u.s_flag  = r[0];
            u.link    = r[1];
            u.word_op = r[2];
            u.ebreak  = (r[6:3] == 4'd0);
            if (r[9:7] == 3'd0) begin
                u.alu_op = ex_pkg::alu_op_e'(5'h18 + {2'b00, r[12:10]});
            end
            drive(duty(), u);
        end
        end_test("random mix");

        $display("%0d tests, %0d mismatches, %0d timeouts", test_cnt, err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
hw/ex_pkg.sv
hw/pipe_reg.sv
hw/alu_unit.sv
hw/store_unit.sv
hw/ex_result_sel.sv
hw/ex_stage_top.sv
sim/tb_ex_stage.sv

// File: Makefile
TOP := tb_ex_stage

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f verilog.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Some tests failed" sim.log; then \
		echo "simulation reported failures"; \
		exit 1; \
	elif ! grep -q "All tests passed" sim.log; then \
		echo "simulation ended without a result line"; \
		exit 1; \
	else \
		echo "simulation clean"; \
	fi

clean:
	rm -rf obj_dir sim.log
